/* vec_settings.svh */
// Vector slice sizing macros
`ifndef VEC_SETTINGS_SVH
`define VEC_SETTINGS_SVH

// elements handled per counter step
`define NUM_LANES 2

// bits per element
`define ELEM_WIDTH 16

`define VLMAX 8      // largest vl
`define NUM_VREGS 4  // vector registers in the file

`endif

/* vec_isa_pkg.sv */
// Vector instruction types
`include "vec_settings.svh"

package vec_isa_pkg;

  // opcode, 3 bits
  typedef enum logic [2:0] {
    VMV  = 3'd0, // vmv.v.x splat
    VADD = 3'd1, // vadd.vx
    VSUB = 3'd2, // vsub.vx
    VAND = 3'd3, // vand.vx
    VXOR = 3'd4  // vxor.vx
  } vop_e;

  // one host instruction
  typedef struct packed {
    vop_e                   op;
    logic [1:0]             vd;     // destination reg
    logic [1:0]             vs2;    // source reg
    logic [`ELEM_WIDTH-1:0] scalar; // rs1 operand
    logic [3:0]             vl;     // vector length
    logic [3:0]             vstart; // first element
  } vec_instr_t;

endpackage

/* vec_pipe_pkg.sv */
// Vector pipeline types
`include "vec_settings.svh"

package vec_pipe_pkg;

  // one lane-wide group of elements
  typedef logic [`NUM_LANES-1:0][`ELEM_WIDTH-1:0] lane_data_t;

  // issued step, decode to execute
  typedef struct packed {
    vec_isa_pkg::vop_e      op;
    logic [1:0]             vd;
    logic [1:0]             vs2;
    logic [`ELEM_WIDTH-1:0] scalar;
    logic [3:0]             offset;    // first element of this step
    logic [`NUM_LANES-1:0]  lane_mask; // lanes below vl
    logic                   last;      // final step of instr
  } vec_uop_t;

  // result step, execute to writeback
  typedef struct packed {
    logic [1:0]            vd;
    logic [3:0]            offset;
    logic [`NUM_LANES-1:0] lane_mask;
    logic                  last;
    lane_data_t            data;      // lane results
  } vec_beat_t;

endpackage

/* element_counter.sv */
// Vector element counter
`timescale 1ns/1ps
`include "vec_settings.svh"

module element_counter (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  load,      // new instr latched
  input  logic [3:0]            vstart,
  input  logic [3:0]            vl,
  input  logic                  step,      // uop accepted
  output logic [3:0]            offset,
  output logic [`NUM_LANES-1:0] lane_mask,
  output logic                  last
);

  logic [4:0] end_sum; // offset + lanes, one spare bit

  assign end_sum = {1'b0, offset} + 5'(`NUM_LANES);
  assign last    = (end_sum >= {1'b0, vl});

  // offset register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      offset <= '0;
    end else if (load) begin
      offset <= vstart; // start at vstart
    end else if (step) begin
      if (last) begin
        offset <= '0;     // wrap after final step
      end else begin
        offset <= offset + 4'(`NUM_LANES);
      end
    end
  end

  // lane active while its element index is below vl
  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_mask
    logic [4:0] elem_idx;
    assign elem_idx     = {1'b0, offset} + 5'(g);
    assign lane_mask[g] = (elem_idx < {1'b0, vl});
  end

endmodule

/* vec_decode.sv */
// Vector decode and issue
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_decode (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   ins_req,
  input  vec_isa_pkg::vec_instr_t ins,
  output logic                   ins_ack,
  output logic                   uop_valid,
  output vec_pipe_pkg::vec_uop_t uop,
  input  logic                   uop_ready,
  input  logic                   retire     // last beat written back
);

  typedef enum logic [1:0] {ST_IDLE, ST_ISSUE, ST_DRAIN} dec_state_e;

  dec_state_e              state;
  vec_isa_pkg::vec_instr_t instr_q;   // latched instruction
  logic                    latch;
  logic                    step;
  logic [3:0]              offset;
  logic [`NUM_LANES-1:0]   lane_mask;
  logic                    last;

  assign latch     = (state == ST_IDLE) && ins_req && !ins_ack; // idle and ack low
  assign uop_valid = (state == ST_ISSUE);
  assign step      = uop_valid && uop_ready;

  element_counter u_counter (
    .CLK(CLK), .nRST(nRST),
    .load(latch), .vstart(ins.vstart), .vl(instr_q.vl), .step(step),
    .offset(offset), .lane_mask(lane_mask), .last(last)
  );

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= ST_IDLE;
      ins_ack <= 1'b0;
    end else begin
      if (latch) begin
        ins_ack <= 1'b1;
      end else if (ins_ack && !ins_req) begin
        ins_ack <= 1'b0; // phase 4
      end
      case (state)
        ST_IDLE:  if (latch) state <= ST_ISSUE;
        ST_ISSUE: if (step && last) state <= ST_DRAIN; // final uop gone
        ST_DRAIN: if (retire) state <= ST_IDLE;
        default:  state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (latch) instr_q <= ins;
  end

  // micro-op from latched fields and counter
  assign uop = '{op: instr_q.op, vd: instr_q.vd, vs2: instr_q.vs2,
                 scalar: instr_q.scalar, offset: offset,
                 lane_mask: lane_mask, last: last};

endmodule

/* vec_stage_fifo.sv */
// Two-entry stage buffer
`timescale 1ns/1ps

module vec_stage_fifo #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  payload_t   mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;  // 0..2
  logic       push;
  logic       pop;

  assign in_ready  = (count != 2'd2); // not full
  assign out_valid = (count != 2'd0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop)  rd_ptr <= ~rd_ptr;
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count; // idle or simultaneous
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (push) mem[wr_ptr] <= in_data;
  end

endmodule

/* vec_regfile.sv */
// Vector register file
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_regfile (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic [1:0]               rd_reg,
  input  logic [3:0]               rd_offset,
  output vec_pipe_pkg::lane_data_t rd_data,
  input  logic                     wr_en,
  input  logic [1:0]               wr_reg,
  input  logic [3:0]               wr_offset,
  input  logic [`NUM_LANES-1:0]    wr_mask,
  input  vec_pipe_pkg::lane_data_t wr_data
);

  localparam int IDX_W = $clog2(`VLMAX);

  logic [`ELEM_WIDTH-1:0] mem [`NUM_VREGS][`VLMAX];
  logic [4:0]             rd_idx [`NUM_LANES];
  logic [4:0]             wr_idx [`NUM_LANES];

  for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
    assign rd_idx[g]  = {1'b0, rd_offset} + 5'(g);
    assign wr_idx[g]  = {1'b0, wr_offset} + 5'(g);
    // past VLMAX reads zero
    assign rd_data[g] = (rd_idx[g] < 5'(`VLMAX)) ? mem[rd_reg][rd_idx[g][IDX_W-1:0]] : '0;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < `NUM_VREGS; r++) begin
        for (int e = 0; e < `VLMAX; e++) mem[r][e] <= '0;
      end
    end else if (wr_en) begin
      for (int l = 0; l < `NUM_LANES; l++) begin
        if (wr_mask[l] && (wr_idx[l] < 5'(`VLMAX))) begin
          mem[wr_reg][wr_idx[l][IDX_W-1:0]] <= wr_data[l]; // masked lanes only
        end
      end
    end
  end

endmodule

/* vec_execute.sv */
// Vector lane execute
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_execute (
  input  logic                     in_valid,
  input  vec_pipe_pkg::vec_uop_t   in_uop,
  output logic                     in_ready,
  output logic                     out_valid,
  output vec_pipe_pkg::vec_beat_t  out_beat,
  input  logic                     out_ready,
  output logic [1:0]               rd_reg,
  output logic [3:0]               rd_offset,
  input  vec_pipe_pkg::lane_data_t rd_data
);

  vec_pipe_pkg::lane_data_t lane_res;

  // handshake passes straight through
  assign out_valid = in_valid;
  assign in_ready  = out_ready;

  // source lanes from vs2 at this offset
  assign rd_reg    = in_uop.vs2;
  assign rd_offset = in_uop.offset;

  always_comb begin
    lane_res = '0;
    for (int l = 0; l < `NUM_LANES; l++) begin
      if (in_uop.lane_mask[l]) begin // inactive lanes stay zero
        case (in_uop.op)
          vec_isa_pkg::VMV:  lane_res[l] = in_uop.scalar;
          vec_isa_pkg::VADD: lane_res[l] = rd_data[l] + in_uop.scalar; // wraps
          vec_isa_pkg::VSUB: lane_res[l] = rd_data[l] - in_uop.scalar;
          vec_isa_pkg::VAND: lane_res[l] = rd_data[l] & in_uop.scalar;
          vec_isa_pkg::VXOR: lane_res[l] = rd_data[l] ^ in_uop.scalar;
          default:           lane_res[l] = '0;
        endcase
      end
    end
  end

  assign out_beat = '{vd: in_uop.vd, offset: in_uop.offset,
                      lane_mask: in_uop.lane_mask, last: in_uop.last,
                      data: lane_res};

endmodule

/* vec_result.sv */
// Vector result and writeback
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_result (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     in_valid,
  input  vec_pipe_pkg::vec_beat_t  in_beat,
  output logic                     in_ready,
  output logic                     res_req,
  output vec_pipe_pkg::vec_beat_t  beat,
  input  logic                     res_ack,
  output logic                     wr_en,
  output logic [1:0]               wr_reg,
  output logic [3:0]               wr_offset,
  output logic [`NUM_LANES-1:0]    wr_mask,
  output vec_pipe_pkg::lane_data_t wr_data,
  output logic                     retire
);

  typedef enum logic [1:0] {ST_PRESENT, ST_WAIT_LOW, ST_POP} res_state_e;

  res_state_e state;

  assign beat      = in_beat;  // fifo head, held until pop
  assign wr_en     = (state == ST_PRESENT) && res_req && res_ack; // one cycle
  assign wr_reg    = in_beat.vd;
  assign wr_offset = in_beat.offset;
  assign wr_mask   = in_beat.lane_mask;
  assign wr_data   = in_beat.data;
  assign in_ready  = (state == ST_POP);
  assign retire    = (state == ST_POP) && in_beat.last;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= ST_PRESENT;
      res_req <= 1'b0;
    end else begin
      case (state)
        ST_PRESENT: begin
          if (res_req && res_ack) begin
            res_req <= 1'b0; // phase 3
            state   <= ST_WAIT_LOW;
          end else if (in_valid && !res_ack) begin
            res_req <= 1'b1;
          end
        end
        ST_WAIT_LOW: if (!res_ack) state <= ST_POP; // host done
        ST_POP:      state <= ST_PRESENT;
        default:     state <= ST_PRESENT;
      endcase
    end
  end

endmodule

/* vec_unit_top.sv */
// Vector execution slice top
`timescale 1ns/1ps
`include "vec_settings.svh"

module vec_unit_top (
  input  logic                    CLK,
  input  logic                    nRST,
  input  logic                    ins_req,
  input  vec_isa_pkg::vec_instr_t ins,
  output logic                    ins_ack,
  output logic                    res_req,
  output vec_pipe_pkg::vec_beat_t beat,
  input  logic                    res_ack
);

  logic                     uop_valid, uop_ready;
  vec_pipe_pkg::vec_uop_t   uop;
  logic                     ex_valid, ex_ready;   // uop fifo to execute
  vec_pipe_pkg::vec_uop_t   ex_uop;
  logic                     bt_valid, bt_ready;   // execute to beat fifo
  vec_pipe_pkg::vec_beat_t  bt_beat;
  logic                     rs_valid, rs_ready;   // beat fifo to result
  vec_pipe_pkg::vec_beat_t  rs_beat;
  logic [1:0]               rd_reg, wr_reg;
  logic [3:0]               rd_offset, wr_offset;
  vec_pipe_pkg::lane_data_t rd_data, wr_data;
  logic                     wr_en, retire;
  logic [`NUM_LANES-1:0]    wr_mask;

  vec_decode u_decode (
    .CLK(CLK), .nRST(nRST), .ins_req(ins_req), .ins(ins), .ins_ack(ins_ack),
    .uop_valid(uop_valid), .uop(uop), .uop_ready(uop_ready), .retire(retire)
  );

  vec_stage_fifo #(.payload_t(vec_pipe_pkg::vec_uop_t)) u_uop_fifo (
    .CLK(CLK), .nRST(nRST), .in_valid(uop_valid), .in_data(uop), .in_ready(uop_ready),
    .out_valid(ex_valid), .out_data(ex_uop), .out_ready(ex_ready)
  );

  vec_execute u_execute (
    .in_valid(ex_valid), .in_uop(ex_uop), .in_ready(ex_ready),
    .out_valid(bt_valid), .out_beat(bt_beat), .out_ready(bt_ready),
    .rd_reg(rd_reg), .rd_offset(rd_offset), .rd_data(rd_data)
  );

  vec_stage_fifo #(.payload_t(vec_pipe_pkg::vec_beat_t)) u_beat_fifo (
    .CLK(CLK), .nRST(nRST), .in_valid(bt_valid), .in_data(bt_beat), .in_ready(bt_ready),
    .out_valid(rs_valid), .out_data(rs_beat), .out_ready(rs_ready)
  );

  vec_result u_result (
    .CLK(CLK), .nRST(nRST), .in_valid(rs_valid), .in_beat(rs_beat), .in_ready(rs_ready),
    .res_req(res_req), .beat(beat), .res_ack(res_ack),
    .wr_en(wr_en), .wr_reg(wr_reg), .wr_offset(wr_offset), .wr_mask(wr_mask),
    .wr_data(wr_data), .retire(retire)
  );

  vec_regfile u_regfile (
    .CLK(CLK), .nRST(nRST), .rd_reg(rd_reg), .rd_offset(rd_offset), .rd_data(rd_data),
    .wr_en(wr_en), .wr_reg(wr_reg), .wr_offset(wr_offset), .wr_mask(wr_mask),
    .wr_data(wr_data)
  );

endmodule

/* vec_unit_assertions.sv */
// Vector unit protocol checks
`timescale 1ns/1ps

module vec_unit_assertions (
  input logic                    CLK,
  input logic                    nRST,
  input logic                    ins_req,
  input logic                    ins_ack,
  input logic                    res_req,
  input logic                    res_ack,
  input vec_pipe_pkg::vec_beat_t beat
);

  int fail_count = 0; // failed assertion count, read by the testbench

  // beat held while host has not acked
  beat_stable: assert property (@(posedge CLK) disable iff (!nRST)
    res_req && !res_ack |=> $stable(beat))
  else begin
    $error("beat changed during result handshake");
    fail_count++;
  end

  // req stays up until ack
  req_held: assert property (@(posedge CLK) disable iff (!nRST)
    res_req && !res_ack |=> res_req)
  else begin
    $error("res_req dropped before res_ack");
    fail_count++;
  end

  // no ack without a request
  ack_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    !ins_req && !ins_ack |=> !ins_ack)
  else begin
    $error("ins_ack rose with no ins_req");
    fail_count++;
  end

  mask_nonzero: assert property (@(posedge CLK) disable iff (!nRST)
    res_req |-> beat.lane_mask != '0)
  else begin
    $error("beat presented with empty lane mask");
    fail_count++;
  end

endmodule

bind vec_unit_top vec_unit_assertions u_assertions (
  .CLK(CLK), .nRST(nRST), .ins_req(ins_req), .ins_ack(ins_ack),
  .res_req(res_req), .res_ack(res_ack), .beat(beat)
);

/* tb_vec_unit.sv */
// Vector unit testbench
`timescale 1ns/1ps
`include "vec_settings.svh"

module tb_vec_unit;

  localparam int TIMEOUT = 100; // cycles per handshake wait

  logic                    CLK;
  logic                    nRST;
  logic                    ins_req;
  vec_isa_pkg::vec_instr_t ins;
  logic                    ins_ack;
  logic                    res_req;
  vec_pipe_pkg::vec_beat_t beat;
  logic                    res_ack;

  logic [`ELEM_WIDTH-1:0] ref_rf [`NUM_VREGS][`VLMAX]; // register file model
  integer                 seed;

  vec_unit_top u_vec_unit_top (.*);

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK; // 40 ns period
  end

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: the %s never happened", what);
    abort_run();
  endtask

  // poll at falling edges until ins_ack or res_req reaches level
  task automatic wait_line(input bit pick_res, input logic level, input string what);
    int cnt;
    cnt = 0;
    @(negedge CLK);
    while ((pick_res ? res_req : ins_ack) !== level) begin
      if (cnt == TIMEOUT) report_timeout(what);
      cnt++;
      @(negedge CLK);
    end
  endtask

  // element rule per opcode, wraps at ELEM_WIDTH
  function automatic logic [`ELEM_WIDTH-1:0] lane_op(input vec_isa_pkg::vop_e op,
      input logic [`ELEM_WIDTH-1:0] src, input logic [`ELEM_WIDTH-1:0] s);
    case (op)
      vec_isa_pkg::VMV:  return s;       // splat
      vec_isa_pkg::VADD: return src + s;
      vec_isa_pkg::VSUB: return src - s;
      vec_isa_pkg::VAND: return src & s;
      vec_isa_pkg::VXOR: return src ^ s;
      default:           return '0;
    endcase
  endfunction

  // host side of the instruction port
  task automatic send_instr(input vec_isa_pkg::vec_instr_t instr);
    @(posedge CLK);
    ins     <= instr;
    ins_req <= 1'b1;
    wait_line(1'b0, 1'b1, "instruction ack rise");
    @(posedge CLK);
    ins_req <= 1'b0; // phase 3
    wait_line(1'b0, 1'b0, "instruction ack fall");
  endtask

  // acks every beat of one instr, checks each against the model
  task automatic collect_beats(input vec_isa_pkg::vec_instr_t instr);
    vec_pipe_pkg::vec_beat_t exp;
    int                      off;
    int                      idx;
    int                      delay;
    int                      nbeats; // beats seen so far
    logic [`ELEM_WIDTH-1:0]  src;
    off    = instr.vstart;
    nbeats = 0;
    do begin
      exp.vd     = instr.vd;
      exp.offset = 4'(off);
      exp.last   = (off + `NUM_LANES >= instr.vl);
      for (int l = 0; l < `NUM_LANES; l++) begin
        idx              = off + l;
        src              = (idx < `VLMAX) ? ref_rf[instr.vs2][idx] : '0;
        exp.lane_mask[l] = (idx < instr.vl);
        exp.data[l]      = exp.lane_mask[l] ? lane_op(instr.op, src, instr.scalar) : '0;
      end
      wait_line(1'b1, 1'b1, "result req rise");
      assert (beat === exp) else begin
        $display("FAIL %0t: beat %0d got %h expected %h", $time, nbeats, beat, exp);
        abort_run();
      end
      delay = $unsigned($random(seed)) % 4; // slow host
      repeat (delay) @(posedge CLK);
      @(posedge CLK);
      res_ack <= 1'b1;
      wait_line(1'b1, 1'b0, "result req fall");
      @(posedge CLK);
      res_ack <= 1'b0;
      for (int l = 0; l < `NUM_LANES; l++) begin
        if (exp.lane_mask[l]) ref_rf[instr.vd][off + l] = exp.data[l];
      end
      nbeats++;
      off += `NUM_LANES;
    end while (!exp.last);
  endtask

  task automatic check_regs();
    @(negedge CLK);
    for (int r = 0; r < `NUM_VREGS; r++) begin
      for (int e = 0; e < `VLMAX; e++) begin
        assert (u_vec_unit_top.u_regfile.mem[r][e] === ref_rf[r][e]) else begin
          $display("FAIL %0t: v%0d[%0d] got %h expected %h", $time, r, e,
                   u_vec_unit_top.u_regfile.mem[r][e], ref_rf[r][e]);
          abort_run();
        end
      end
    end
  endtask

  task automatic run_instr(input vec_isa_pkg::vop_e op, input int vd, input int vs2,
      input logic [`ELEM_WIDTH-1:0] scalar, input int vl, input int vstart);
    vec_isa_pkg::vec_instr_t instr;
    instr = '{op: op, vd: 2'(vd), vs2: 2'(vs2), scalar: scalar,
              vl: 4'(vl), vstart: 4'(vstart)};
    send_instr(instr);
    collect_beats(instr);
    check_regs();
  endtask

  task automatic test_reset();
    @(negedge CLK);
    assert (ins_ack === 1'b0 && res_req === 1'b0) else begin
      $display("FAIL %0t: ins_ack %b res_req %b after reset", $time, ins_ack, res_req);
      abort_run();
    end
  endtask

  // four full beats, offsets and last checked per beat
  task automatic test_splat();
    run_instr(vec_isa_pkg::VMV, 1, 0, 16'hA5C3, 8, 0);
  endtask

  // odd vl, last beat has one lane masked
  task automatic test_arith();
    run_instr(vec_isa_pkg::VADD, 2, 1, 16'h7000, 7, 0); // wraps
    run_instr(vec_isa_pkg::VSUB, 3, 1, 16'hB000, 5, 0);
    run_instr(vec_isa_pkg::VAND, 3, 2, 16'h0FF0, 3, 0);
    run_instr(vec_isa_pkg::VXOR, 2, 1, 16'hFFFF, 7, 0);
  endtask

  task automatic test_vstart();
    run_instr(vec_isa_pkg::VMV, 0, 0, 16'h1111, 8, 0);
    run_instr(vec_isa_pkg::VMV, 0, 0, 16'h0707, 8, 3);  // v0[0..2] keep 1111
    run_instr(vec_isa_pkg::VADD, 3, 0, 16'h0001, 8, 0);
  endtask

  task automatic test_random();
    int                     op;
    int                     vd;
    int                     vs2;
    logic [`ELEM_WIDTH-1:0] s;
    int                     vl;
    int                     vstart;
    for (int i = 0; i < 24; i++) begin
      op     = $unsigned($random(seed)) % 5;
      vd     = $random(seed) & 3;
      vs2    = $random(seed) & 3;
      s      = $random(seed);
      vl     = 1 + $unsigned($random(seed)) % `VLMAX;
      vstart = $unsigned($random(seed)) % vl; // always below vl
      run_instr(vec_isa_pkg::vop_e'(op), vd, vs2, s, vl, vstart);
    end
  endtask

  initial begin
    seed    = 32'hba55;
    nRST    = 1'b0;
    ins_req = 1'b0;
    ins     = '0;
    res_ack = 1'b0;
    for (int r = 0; r < `NUM_VREGS; r++) begin
      for (int e = 0; e < `VLMAX; e++) ref_rf[r][e] = '0;
    end
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    test_reset();
    test_splat();
    test_arith();
    test_vstart();
    test_random();
    if (u_vec_unit_top.u_assertions.fail_count == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

/* sim.f */
+incdir+.
vec_isa_pkg.sv
vec_pipe_pkg.sv
element_counter.sv
vec_decode.sv
vec_stage_fifo.sv
vec_regfile.sv
vec_execute.sv
vec_result.sv
vec_unit_top.sv
vec_unit_assertions.sv
tb_vec_unit.sv

/* Bender.yml */
package:
  name: vec_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - vec_isa_pkg.sv
      - vec_pipe_pkg.sv
      - element_counter.sv
      - vec_decode.sv
      - vec_stage_fifo.sv
      - vec_regfile.sv
      - vec_execute.sv
      - vec_result.sv
      - vec_unit_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - vec_unit_assertions.sv
      - tb_vec_unit.sv
